/* include/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// fetch address after reset, boot rom region of kseg1
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// instruction memory depth in 32-bit words
`define IRAM_WORDS 4096

// registers r2 onward loaded, or-ed and stored by the built-in program
`define PROG_COUNT 30

// byte address where the first result word is stored
`define STORE_BASE 32'h0000_0100

`endif

/* source/mips_pkg.sv */
package mips_pkg;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // funct field of SPECIAL (r-type) instructions
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_OR   = 6'h25
    } funct_e;

    // r-type layout, i-type immediate is {rd, shamt, funct}
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_OR     = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    // decoded control bundle, one per instruction
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        // ori zero-extends, everything else sign-extends
        logic    zero_ext;
        logic    reg_write;
        // write rd instead of rt
        logic    dest_rd;
        logic    mem_read;
        logic    mem_write;
        logic    jump_reg;
        logic    illegal;
    } ctrl_t;

    // data port request, answered combinationally on dmem_rdata
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } dmem_req_t;

    typedef enum logic {
        HALTED  = 1'b0,
        RUNNING = 1'b1
    } run_state_e;

endpackage

/* source/alu.sv */
module alu
    import mips_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    always_comb begin
        case (op)
            // addu, addiu and lw/sw address generation
            ALU_ADD:    result = a + b;
            // or and ori
            ALU_OR:     result = a | b;
            // operand b straight through
            ALU_PASS_B: result = b;
            default:    result = b;
        endcase
    end

endmodule

/* source/decoder.sv */
module decoder
    import mips_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl
);

    always_comb begin
        // default is a no-op with every strobe low
        ctrl        = '0;
        ctrl.alu_op = ALU_PASS_B;
        case (instr.opcode)
            OP_SPECIAL: begin
                case (instr.funct)
                    FN_JR: begin
                        ctrl.jump_reg = 1'b1;
                    end
                    FN_ADDU: begin
                        ctrl.alu_op    = ALU_ADD;
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                    end
                    FN_OR: begin
                        ctrl.alu_op    = ALU_OR;
                        ctrl.reg_write = 1'b1;
                        ctrl.dest_rd   = 1'b1;
                    end
                    default: begin
                        // only the all-zero nop is accepted here
                        ctrl.illegal = (instr != '0);
                    end
                endcase
            end
            OP_ORI: begin
                ctrl.alu_op    = ALU_OR;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_ADDIU: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                // address = rs + simm, result comes from the data port
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* source/reg_file.sv */
module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_index,
    input  logic [4:0]  rt_index,
    output logic [31:0] rs_value,
    output logic [31:0] rt_value,
    input  logic        write_enable,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_value
);

    logic [31:0] regs [0:31];

    // two asynchronous read ports
    assign rs_value = regs[rs_index];
    assign rt_value = regs[rt_index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_index != 5'd0)) begin
            // r0 is hardwired, writes to it are dropped
            regs[write_index] <= write_value;
        end
    end

    // r0 must survive every write-back the core issues
    r0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n) regs[0] == 32'd0
    );

endmodule

/* source/instr_ram.sv */
`include "mips_macros.svh"

module instr_ram
    import mips_pkg::*;
(
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    localparam int IDX_W = $clog2(`IRAM_WORDS);

    logic [31:0] mem [0:`IRAM_WORDS-1];

    // byte offset from the reset vector, then word index
    logic [31:0]      offset;
    logic [IDX_W-1:0] word_index;

    assign offset     = instr_address - `MIPS_RESET_VECTOR;
    assign word_index = offset[IDX_W+1:2];

    // combinational read, no latency
    assign instr_readdata = mem[word_index];

    // build an i-type word from its fields
    function automatic instr_t make_itype(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        instr_t w;
        w.opcode = op;
        w.rs     = rs;
        w.rt     = rt;
        {w.rd, w.shamt, w.funct} = imm;
        return w;
    endfunction

    initial begin
        instr_t w;
        int     n;
        // unused words stay zero, a harmless sll r0
        for (int i = 0; i < `IRAM_WORDS; i++) begin
            mem[i] = '0;
        end
        n = 0;
        // lw r(k+2), 4k(r0)
        for (int k = 0; k < `PROG_COUNT; k++) begin
            mem[n] = make_itype(OP_LW, 5'd0, 5'(k + 2), 16'(k * 4));
            n++;
        end
        // ori r(k+2), r(k+2), 0xf
        for (int k = 0; k < `PROG_COUNT; k++) begin
            mem[n] = make_itype(OP_ORI, 5'(k + 2), 5'(k + 2), 16'h000F);
            n++;
        end
        // sw r(k+2), STORE_BASE+4k(r0)
        for (int k = 0; k < `PROG_COUNT; k++) begin
            mem[n] = make_itype(OP_SW, 5'd0, 5'(k + 2), 16'(`STORE_BASE + k * 4));
            n++;
        end
        // jr r0 ends the program, lands at word 90
        w        = '0;
        w.opcode = OP_SPECIAL;
        w.funct  = FN_JR;
        mem[n]   = w;
    end

endmodule

/* source/mips_core.sv */
`include "mips_macros.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output dmem_req_t   dmem_req,
    input  logic [31:0] dmem_rdata,
    output logic        active
);

    instr_t     instr;
    ctrl_t      ctrl;
    run_state_e state;
    // set by reset, lets the core start one edge after rst_n rises
    logic       boot_pending;
    logic       running;
    logic       halt_now;

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [15:0] imm;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [4:0]  write_index;
    logic [31:0] write_value;

    assign instr         = instr_t'(instr_readdata);
    assign instr_address = pc;
    assign running       = (state == RUNNING);
    assign active        = running;

    decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    reg_file u_reg_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs_index     (instr.rs),
        .rt_index     (instr.rt),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .write_enable (running && ctrl.reg_write),
        .write_index  (write_index),
        .write_value  (write_value)
    );

    // i-type immediate lives in the low half of the word
    assign imm     = {instr.rd, instr.shamt, instr.funct};
    assign imm_ext = ctrl.zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign alu_b   = ctrl.use_imm ? imm_ext : rt_value;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rs_value),
        .b      (alu_b),
        .result (alu_result)
    );

    // r-type writes rd, i-type writes rt
    assign write_index = ctrl.dest_rd ? instr.rd : instr.rt;
    assign write_value = ctrl.mem_read ? dmem_rdata : alu_result;

    // data port, strobes only while running
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rt_value;
    assign dmem_req.read  = running && ctrl.mem_read;
    assign dmem_req.write = running && ctrl.mem_write;

    // jr to address zero is the halt convention
    assign halt_now = ctrl.illegal || (ctrl.jump_reg && (rs_value == 32'd0));
    assign pc_next  = ctrl.jump_reg ? rs_value : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= `MIPS_RESET_VECTOR;
            state        <= HALTED;
            boot_pending <= 1'b1;
        end else if (boot_pending) begin
            state        <= RUNNING;
            boot_pending <= 1'b0;
        end else if (running) begin
            if (halt_now) begin
                // pc freezes on the halting instruction
                state <= HALTED;
            end else begin
                pc <= pc_next;
            end
        end
    end

    // jr targets come from registers, so check alignment over the whole run
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) running |-> (pc[1:0] == 2'b00)
    );

    // decoder and gating together must never issue both strobes
    one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) !(dmem_req.read && dmem_req.write)
    );

endmodule

/* source/mips_cpu.sv */
module mips_cpu
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output dmem_req_t   dmem_req,
    input  logic [31:0] dmem_rdata,
    output logic        active
);

    // fetch path between core and instruction memory
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;

    mips_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .dmem_req       (dmem_req),
        .dmem_rdata     (dmem_rdata),
        .active         (active)
    );

    instr_ram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

endmodule

/* tests/mips_cpu_tb.sv */
`include "mips_macros.svh"

module mips_cpu_tb
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 200;
    localparam int QUIET_CYCLES = 50;

    // one row per register handled by the built-in program
    typedef struct packed {
        logic [31:0] load_addr;
        logic [31:0] load_data;
        logic [31:0] store_addr;
        logic [31:0] store_data;
    } access_row_t;

    logic        clk;
    logic        rst_n;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic        active;

    logic [31:0] data_mem [0:31];
    access_row_t table_rows [`PROG_COUNT];
    // free-running count of rising edges, used to time the strobes
    int          cycle_count = 0;
    logic [31:0] write_addr_log [$];
    logic [31:0] write_data_log [$];

    mips_cpu DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .active     (active)
    );

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // data memory answers in the same cycle, 32 words on addr[6:2]
    assign dmem_rdata = data_mem[dmem_req.addr[6:2]];

    // a store lands at the rising edge that closes its cycle
    always @(posedge clk) begin
        if (rst_n && dmem_req.write) begin
            write_addr_log.push_back(dmem_req.addr);
            write_data_log.push_back(dmem_req.wdata);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    // holds rst_n low on falling edges, every output must stay quiet meanwhile
    task automatic apply_reset();
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("read strobe in reset", 32'd0, {31'd0, dmem_req.read});
            check_value("write strobe in reset", 32'd0, {31'd0, dmem_req.write});
            check_value("active in reset", 32'd0, {31'd0, active});
        end
        rst_n = 1'b1;
    endtask

    // samples at falling edges until the wanted strobe shows
    // the other strobe has to stay low the whole time
    task automatic wait_for_strobe(input bit want_write, input string what);
        int waited;
        waited = 0;
        while ((want_write ? dmem_req.write : dmem_req.read) !== 1'b1) begin
            check_value({what, " other strobe"}, 32'd0,
                        {31'd0, want_write ? dmem_req.read : dmem_req.write});
            if (waited == WAIT_LIMIT) begin
                fail_run({"timeout while waiting for ", what});
            end
            @(negedge clk);
            waited++;
        end
        check_value({what, " other strobe"}, 32'd0,
                    {31'd0, want_write ? dmem_req.read : dmem_req.write});
    endtask

    initial begin
        logic [31:0] seed;
        int          boot_cycle;
        int          first_read_cycle;
        int          last_read_cycle;
        int          waited;
        clk   = 1'b0;
        rst_n = 1'b0;

        // memory contents from the lcg
        seed = 32'h91d5f587;
        for (int i = 0; i < 32; i++) begin
            seed        = lcg_next(seed);
            data_mem[i] = seed;
        end

        // expected accesses, load k then store k with the low nibble set
        for (int k = 0; k < `PROG_COUNT; k++) begin
            table_rows[k].load_addr  = 32'(4 * k);
            table_rows[k].load_data  = data_mem[k];
            table_rows[k].store_addr = `STORE_BASE + 32'(4 * k);
            table_rows[k].store_data = table_rows[k].load_data | 32'h0000_000F;
        end

        apply_reset();
        @(negedge clk);
        check_value("active after reset", 32'd1, {31'd0, active});
        boot_cycle = cycle_count;

        // loads back to back from the first cycle
        first_read_cycle = boot_cycle;
        last_read_cycle  = boot_cycle;
        for (int k = 0; k < `PROG_COUNT; k++) begin
            wait_for_strobe(1'b0, $sformatf("load %0d", k));
            check_value($sformatf("load %0d cycle", k), 32'(first_read_cycle + k),
                        32'(cycle_count));
            check_value($sformatf("load %0d address", k), table_rows[k].load_addr,
                        dmem_req.addr);
            last_read_cycle = cycle_count;
            @(negedge clk);
        end

        // 30 ori cycles are quiet, so store k lands 31 + k cycles after the last load
        for (int k = 0; k < `PROG_COUNT; k++) begin
            wait_for_strobe(1'b1, $sformatf("store %0d", k));
            check_value($sformatf("store %0d cycle", k), 32'(last_read_cycle + 31 + k),
                        32'(cycle_count));
            check_value($sformatf("store %0d address", k), table_rows[k].store_addr,
                        dmem_req.addr);
            check_value($sformatf("store %0d data", k), table_rows[k].store_data,
                        dmem_req.wdata);
            @(negedge clk);
        end

        // jr r0 halts the core
        waited = 0;
        while (active !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                fail_run("timeout: active did not fall after the last store");
            end
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            check_value("read strobe after halt", 32'd0, {31'd0, dmem_req.read});
            check_value("write strobe after halt", 32'd0, {31'd0, dmem_req.write});
            check_value("active after halt", 32'd0, {31'd0, active});
            @(negedge clk);
        end

        // what the memory model actually received
        check_value("stores recorded", 32'(`PROG_COUNT), 32'(write_addr_log.size()));
        for (int k = 0; k < `PROG_COUNT; k++) begin
            check_value($sformatf("logged store %0d address", k), table_rows[k].store_addr,
                        write_addr_log[k]);
            check_value($sformatf("logged store %0d data", k), table_rows[k].store_data,
                        write_data_log[k]);
        end

        // second reset pulse restarts the program from the vector
        apply_reset();
        @(negedge clk);
        check_value("active after second reset", 32'd1, {31'd0, active});
        wait_for_strobe(1'b0, "load after second reset");
        check_value("load after second reset address", table_rows[0].load_addr,
                    dmem_req.addr);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
source/mips_pkg.sv
source/alu.sv
source/decoder.sv
source/reg_file.sv
source/instr_ram.sv
source/mips_core.sv
source/mips_cpu.sv
tests/mips_cpu_tb.sv

/* Makefile */
# Verilator build and run of the single-cycle MIPS testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	rm -rf obj_dir $(LOG)
	verilator --binary --timing -Wno-fatal --top-module mips_cpu_tb -f all.f -o mips_cpu_sim
	./obj_dir/mips_cpu_sim | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
